//--- run.sh
#!/bin/sh
# Build and run the back-end testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module backend_tb \
    -Mdir obj_dir

./obj_dir/Vbackend_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- testbench/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb import cpu_pkg::*; ();

    localparam int reset_cycles = 5;
    localparam int max_vectors  = 64;

    // Each line of the vector file holds the inputs first and the expected outputs after them.
    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic [2:0] alu_op;
        pc_t      pc_next;
        pc_t      branch_offset;
        data_t    operand_a;
        data_t    operand_b;
        data_t    store_data;
        reg_num_t dest_reg;
        logic     exp_taken;
        pc_t      exp_target;
        logic     exp_wb_write;
        reg_num_t exp_wb_dest;
        data_t    exp_wb_data;
    } vector_t;

    logic     i_clock;
    logic     rst_n;
    logic     ex_reg_write;
    logic     ex_mem_to_reg;
    logic     ex_mem_read;
    logic     ex_mem_write;
    logic     ex_branch;
    alu_op_t  ex_alu_op;
    pc_t      ex_pc_next;
    pc_t      ex_branch_offset;
    data_t    ex_operand_a;
    data_t    ex_operand_b;
    data_t    ex_store_data;
    reg_num_t ex_dest_reg;
    logic     branch_taken;
    pc_t      branch_target;
    logic     wb_reg_write;
    reg_num_t wb_dest_reg;
    data_t    wb_data;

    vector_t vectors [0:max_vectors-1];
    int      num_vectors = 0;

    // Expected results wait here until the pipeline delivers them.
    vector_t branch_pending [$];
    int      branch_due [$];
    vector_t wb_pending [$];
    int      wb_due [$];

    int check_count    = 0;
    int mismatch_count = 0;
    int other_errors   = 0;
    int cycle_count    = 0;
    int cycle_limit    = reset_cycles + max_vectors + 20;

    backend_top UUT (
        .i_clock          (i_clock),
        .rst_n            (rst_n),
        .ex_reg_write     (ex_reg_write),
        .ex_mem_to_reg    (ex_mem_to_reg),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_branch        (ex_branch),
        .ex_alu_op        (ex_alu_op),
        .ex_pc_next       (ex_pc_next),
        .ex_branch_offset (ex_branch_offset),
        .ex_operand_a     (ex_operand_a),
        .ex_operand_b     (ex_operand_b),
        .ex_store_data    (ex_store_data),
        .ex_dest_reg      (ex_dest_reg),
        .branch_taken     (branch_taken),
        .branch_target    (branch_target),
        .wb_reg_write     (wb_reg_write),
        .wb_dest_reg      (wb_dest_reg),
        .wb_data          (wb_data)
    );

    initial begin
        i_clock = 1'b0;
        forever begin
            #50;
            i_clock = ~i_clock;
        end
    end

    // ****************************************
    // Helpers
    // ****************************************

    task compare_value(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task load_vectors();
        int               fd;
        int               count;
        logic [8*200-1:0] line;
        logic [31:0]      field [0:16];
        vector_t          v;
        fd = $fopen("testbench/backend_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open testbench/backend_vectors.txt");
        end else begin
            while (!$feof(fd) && num_vectors < max_vectors) begin
                count = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                field[0], field[1], field[2], field[3], field[4],
                                field[5], field[6], field[7], field[8], field[9],
                                field[10], field[11], field[12], field[13],
                                field[14], field[15], field[16]);
                if (count == 17) begin
                    v.reg_write     = field[0][0];
                    v.mem_to_reg    = field[1][0];
                    v.mem_read      = field[2][0];
                    v.mem_write     = field[3][0];
                    v.branch        = field[4][0];
                    v.alu_op        = field[5][2:0];
                    v.pc_next       = field[6][pc_width-1:0];
                    v.branch_offset = field[7][pc_width-1:0];
                    v.operand_a     = field[8][data_width-1:0];
                    v.operand_b     = field[9][data_width-1:0];
                    v.store_data    = field[10][data_width-1:0];
                    v.dest_reg      = field[11][reg_width-1:0];
                    v.exp_taken     = field[12][0];
                    v.exp_target    = field[13][pc_width-1:0];
                    v.exp_wb_write  = field[14][0];
                    v.exp_wb_dest   = field[15][reg_width-1:0];
                    v.exp_wb_data   = field[16][data_width-1:0];
                    vectors[num_vectors] = v;
                    num_vectors++;
                end else begin
                    // A comment line stops the scan, so the rest of that line is skipped.
                    void'($fgets(line, fd));
                end
            end
            $fclose(fd);
        end
    endtask

    task drive_vector(input vector_t v);
        ex_reg_write     = v.reg_write;
        ex_mem_to_reg    = v.mem_to_reg;
        ex_mem_read      = v.mem_read;
        ex_mem_write     = v.mem_write;
        ex_branch        = v.branch;
        ex_alu_op        = alu_op_t'(v.alu_op);
        ex_pc_next       = v.pc_next;
        ex_branch_offset = v.branch_offset;
        ex_operand_a     = v.operand_a;
        ex_operand_b     = v.operand_b;
        ex_store_data    = v.store_data;
        ex_dest_reg      = v.dest_reg;
    endtask

    // Branch results are due one cycle after issue, write-back two cycles after.
    task check_pending(input int cycle);
        vector_t v;
        if (branch_due.size() > 0 && branch_due[0] == cycle) begin
            v = branch_pending.pop_front();
            void'(branch_due.pop_front());
            compare_value("branch_taken", 32'(v.exp_taken), 32'(branch_taken));
            compare_value("branch_target", 32'(v.exp_target), 32'(branch_target));
        end
        if (wb_due.size() > 0 && wb_due[0] == cycle) begin
            v = wb_pending.pop_front();
            void'(wb_due.pop_front());
            compare_value("wb_reg_write", 32'(v.exp_wb_write), 32'(wb_reg_write));
            if (v.exp_wb_write) begin
                compare_value("wb_dest_reg", 32'(v.exp_wb_dest), 32'(wb_dest_reg));
                compare_value("wb_data", 32'(v.exp_wb_data), 32'(wb_data));
            end
        end
    endtask

    task report_results();
        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
    endtask

    // ****************************************
    // Stimulus and checks
    // ****************************************

    initial begin
        vector_t reset_vec;
        int      k;
        // A taken branch and a register write sit at the inputs during reset.
        // The outputs stay low only if reset clears the pipeline.
        reset_vec           = '0;
        reset_vec.reg_write = 1'b1;
        reset_vec.branch    = 1'b1;
        rst_n = 1'b0;
        drive_vector(reset_vec);
        load_vectors();
        if (num_vectors == 0) begin
            other_errors++;
            $display("no vectors were read from the vector file");
        end
        cycle_limit = reset_cycles + num_vectors + 20;

        repeat (reset_cycles) @(posedge i_clock);
        @(negedge i_clock);
        compare_value("branch_taken", 32'd0, 32'(branch_taken));
        compare_value("wb_reg_write", 32'd0, 32'(wb_reg_write));
        rst_n = 1'b1;
        drive_vector('0);

        // Nothing may be taken or written in the idle cycle after reset.
        @(negedge i_clock);
        compare_value("branch_taken", 32'd0, 32'(branch_taken));
        compare_value("wb_reg_write", 32'd0, 32'(wb_reg_write));

        for (k = 0; k < num_vectors + 2; k++) begin
            if (k > 0) begin
                @(negedge i_clock);
            end
            check_pending(k);
            if (k < num_vectors) begin
                drive_vector(vectors[k]);
                branch_pending.push_back(vectors[k]);
                branch_due.push_back(k + 1);
                wb_pending.push_back(vectors[k]);
                wb_due.push_back(k + 2);
            end else begin
                drive_vector('0);
            end
        end

        report_results();
        $finish;
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge i_clock);
            cycle_count++;
        end
        other_errors++;
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        report_results();
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/backend_vectors.txt
# rw m2r mrd mwr br alu_op pc_next offset op_a op_b st_data dest, then expected
# taken target (one cycle later) and wb_write wb_dest wb_data (two cycles later), all hex
# ALU operations
1 0 0 0 0 0 01 00 12 34 00 01 0 01 1 01 46
1 0 0 0 0 1 02 00 50 20 00 02 0 02 1 02 30
1 0 0 0 0 1 03 00 05 07 00 03 0 03 1 03 fe
1 0 0 0 0 2 04 00 f0 3c 00 04 0 04 1 04 30
1 0 0 0 0 3 05 00 a0 05 00 05 0 05 1 05 a5
1 0 0 0 0 4 06 00 03 80 00 06 0 06 1 06 01
1 0 0 0 0 4 07 00 80 03 00 07 0 07 1 07 00
1 0 0 0 0 4 08 00 42 42 00 08 0 08 1 08 00
1 0 0 0 0 0 09 00 ff 02 00 1f 0 09 1 1f 01
# Stores and loads
0 0 0 1 0 0 0a 00 10 05 a7 00 0 0a 0 00 00
1 1 1 0 0 0 0b 00 15 00 00 09 0 0b 1 09 a7
0 0 0 1 0 0 0c 00 20 00 3c 00 0 0c 0 00 00
0 0 0 1 0 0 0d 00 30 0f 5a 00 0 0d 0 00 00
0 0 0 1 0 0 0e 00 15 00 99 00 0 0e 0 00 00
1 1 1 0 0 0 0f 00 1f 01 00 0a 0 0f 1 0a 3c
1 1 1 0 0 0 10 00 3f 00 00 0b 0 10 1 0b 5a
1 1 1 0 0 0 11 00 0a 0b 00 0c 0 11 1 0c 99
# Branches
0 0 0 0 1 1 12 08 22 22 00 00 1 1a 0 00 00
0 0 0 0 1 1 13 04 22 21 00 00 0 17 0 00 00
0 0 0 0 1 1 3c 0a 7f 7f 00 00 1 06 0 00 00
0 0 0 0 1 2 14 3e 0f f0 00 00 1 12 0 00 00
# Bubble, then more traffic
0 0 0 0 0 0 00 00 00 00 00 00 0 00 0 00 00
1 0 0 0 0 0 15 00 01 01 00 0d 0 15 1 0d 02
1 0 0 0 0 3 16 00 00 00 00 0e 0 16 1 0e 00
1 1 1 0 0 0 17 00 3f 00 00 10 0 17 1 10 5a
0 0 0 0 0 0 00 00 00 00 00 00 0 00 0 00 00

//--- verilog.f
verilog/cpu_pkg.sv
verilog/ex_mem_if.sv
verilog/execute_stage.sv
verilog/ex_mem_reg.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/backend_top.sv
testbench/backend_tb.sv

//--- verilog/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top import cpu_pkg::*; (
    input  logic     i_clock,
    input  logic     rst_n,
    input  logic     ex_reg_write,
    input  logic     ex_mem_to_reg,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_branch,
    input  alu_op_t  ex_alu_op,
    input  pc_t      ex_pc_next,
    input  pc_t      ex_branch_offset,
    input  data_t    ex_operand_a,
    input  data_t    ex_operand_b,
    input  data_t    ex_store_data,
    input  reg_num_t ex_dest_reg,
    output logic     branch_taken,
    output pc_t      branch_target,
    output logic     wb_reg_write,
    output reg_num_t wb_dest_reg,
    output data_t    wb_data
);

    data_t load_data;

    ex_mem_if ex_bus ();
    ex_mem_if mem_bus ();

    // ****************************************
    // Pipeline stages
    // ****************************************

    execute_stage u_execute_stage (
        .reg_write     (ex_reg_write),
        .mem_to_reg    (ex_mem_to_reg),
        .mem_read      (ex_mem_read),
        .mem_write     (ex_mem_write),
        .branch        (ex_branch),
        .alu_op        (ex_alu_op),
        .pc_next       (ex_pc_next),
        .branch_offset (ex_branch_offset),
        .operand_a     (ex_operand_a),
        .operand_b     (ex_operand_b),
        .store_data    (ex_store_data),
        .dest_reg      (ex_dest_reg),
        .ex_bus        (ex_bus.producer)
    );

    ex_mem_reg u_ex_mem_reg (
        .i_clock (i_clock),
        .rst_n   (rst_n),
        .ex_bus  (ex_bus.consumer),
        .mem_bus (mem_bus.producer)
    );

    memory_stage u_memory_stage (
        .i_clock       (i_clock),
        .mem_bus       (mem_bus.consumer),
        .load_data     (load_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    writeback_stage u_writeback_stage (
        .i_clock      (i_clock),
        .rst_n        (rst_n),
        .mem_bus      (mem_bus.consumer),
        .load_data    (load_data),
        .wb_reg_write (wb_reg_write),
        .wb_dest_reg  (wb_dest_reg),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

// ****************************************
// Widths and types shared by the back end.
// ****************************************

package cpu_pkg;

    // Program counter and branch target width.
    localparam int pc_width = 6;

    // Register number width.
    localparam int reg_width = 5;

    // Operand and result width.
    localparam int data_width = 8;

    // The data memory holds 64 bytes.
    localparam int mem_addr_width = 6;

    typedef logic [pc_width-1:0] pc_t;

    typedef logic [reg_width-1:0] reg_num_t;

    typedef logic [data_width-1:0] data_t;

    // ALU operations selected by the decoder.
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/ex_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

// Signal group between the execute stage and the memory stage.
interface ex_mem_if import cpu_pkg::*; ();

    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    pc_t      branch_address;
    logic     zero;
    data_t    alu_result;
    data_t    store_data;
    reg_num_t dest_reg;

    modport producer (
        output reg_write,
        output mem_to_reg,
        output mem_read,
        output mem_write,
        output branch,
        output branch_address,
        output zero,
        output alu_result,
        output store_data,
        output dest_reg
    );

    modport consumer (
        input reg_write,
        input mem_to_reg,
        input mem_read,
        input mem_write,
        input branch,
        input branch_address,
        input zero,
        input alu_result,
        input store_data,
        input dest_reg
    );

endinterface

`default_nettype wire

//--- verilog/ex_mem_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg import cpu_pkg::*; (
    input  logic       i_clock,
    input  logic       rst_n,
    ex_mem_if.consumer ex_bus,
    ex_mem_if.producer mem_bus
);

    logic     reg_write_q;
    logic     mem_to_reg_q;
    logic     mem_read_q;
    logic     mem_write_q;
    logic     branch_q;
    pc_t      branch_address_q;
    logic     zero_q;
    data_t    alu_result_q;
    data_t    store_data_q;
    reg_num_t dest_reg_q;

    // ****************************************
    // Control bits
    // ****************************************

    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            mem_read_q   <= 1'b0;
            mem_write_q  <= 1'b0;
            branch_q     <= 1'b0;
        end else begin
            reg_write_q  <= ex_bus.reg_write;
            mem_to_reg_q <= ex_bus.mem_to_reg;
            mem_read_q   <= ex_bus.mem_read;
            mem_write_q  <= ex_bus.mem_write;
            branch_q     <= ex_bus.branch;
        end
    end

    // ****************************************
    // Data fields
    // ****************************************

    always_ff @(posedge i_clock) begin
        branch_address_q <= ex_bus.branch_address;
        zero_q           <= ex_bus.zero;
        alu_result_q     <= ex_bus.alu_result;
        store_data_q     <= ex_bus.store_data;
        dest_reg_q       <= ex_bus.dest_reg;
    end

    assign mem_bus.reg_write      = reg_write_q;
    assign mem_bus.mem_to_reg     = mem_to_reg_q;
    assign mem_bus.mem_read       = mem_read_q;
    assign mem_bus.mem_write      = mem_write_q;
    assign mem_bus.branch         = branch_q;
    assign mem_bus.branch_address = branch_address_q;
    assign mem_bus.zero           = zero_q;
    assign mem_bus.alu_result     = alu_result_q;
    assign mem_bus.store_data     = store_data_q;
    assign mem_bus.dest_reg       = dest_reg_q;

    // An instruction is either a load or a store, never both.
    a_no_read_and_write: assert property (
        @(posedge i_clock) disable iff (!rst_n)
        !(ex_bus.mem_read && ex_bus.mem_write)
    );

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic       reg_write,
    input  logic       mem_to_reg,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       branch,
    input  alu_op_t    alu_op,
    input  pc_t        pc_next,
    input  pc_t        branch_offset,
    input  data_t      operand_a,
    input  data_t      operand_b,
    input  data_t      store_data,
    input  reg_num_t   dest_reg,
    ex_mem_if.producer ex_bus
);

    data_t alu_result;
    pc_t   branch_address;

    // ****************************************
    // ALU
    // ****************************************

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = operand_a + operand_b;
            end
            alu_sub: begin
                alu_result = operand_a - operand_b;
            end
            alu_and: begin
                alu_result = operand_a & operand_b;
            end
            alu_or: begin
                alu_result = operand_a | operand_b;
            end
            alu_slt: begin
                // Unsigned compare, result is 1 or 0.
                alu_result = (operand_a < operand_b) ? data_t'(1) : data_t'(0);
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // ****************************************
    // Branch target
    // ****************************************

    // The sum wraps at the PC width, so the target is taken modulo 64.
    assign branch_address = pc_next + branch_offset;

    // Drive the EX/MEM group.
    assign ex_bus.reg_write      = reg_write;
    assign ex_bus.mem_to_reg     = mem_to_reg;
    assign ex_bus.mem_read       = mem_read;
    assign ex_bus.mem_write      = mem_write;
    assign ex_bus.branch         = branch;
    assign ex_bus.branch_address = branch_address;
    assign ex_bus.zero           = (alu_result == '0);
    assign ex_bus.alu_result     = alu_result;
    assign ex_bus.store_data     = store_data;
    assign ex_bus.dest_reg       = dest_reg;

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import cpu_pkg::*; (
    input  logic       i_clock,
    ex_mem_if.consumer mem_bus,
    output data_t      load_data,
    output logic       branch_taken,
    output pc_t        branch_target
);

    localparam int mem_depth = 1 << mem_addr_width;

    data_t                     mem [0:mem_depth-1];
    logic [mem_addr_width-1:0] mem_addr;

    // ****************************************
    // Data memory
    // ****************************************

    // Only the low bits of the ALU result address the memory.
    assign mem_addr = mem_bus.alu_result[mem_addr_width-1:0];

    always_ff @(posedge i_clock) begin
        if (mem_bus.mem_write) begin
            mem[mem_addr] <= mem_bus.store_data;
        end
    end

    // Asynchronous read, so a load sees a store written one edge earlier.
    assign load_data = mem[mem_addr];

    // ****************************************
    // Branch decision
    // ****************************************

    // Taken when the compare in execute came out equal.
    assign branch_taken  = mem_bus.branch & mem_bus.zero;
    assign branch_target = mem_bus.branch_address;

    // Addresses computed in execute must fall inside the 64-byte memory.
    a_addr_in_range: assert property (
        @(posedge i_clock)
        (mem_bus.mem_read || mem_bus.mem_write)
            |-> (mem_bus.alu_result[data_width-1:mem_addr_width] == '0)
    );

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage import cpu_pkg::*; (
    input  logic       i_clock,
    input  logic       rst_n,
    ex_mem_if.consumer mem_bus,
    input  data_t      load_data,
    output logic       wb_reg_write,
    output reg_num_t   wb_dest_reg,
    output data_t      wb_data
);

    data_t wb_data_next;

    // Loads write back memory data, everything else the ALU result.
    assign wb_data_next = mem_bus.mem_to_reg ? load_data : mem_bus.alu_result;

    // ****************************************
    // MEM/WB register
    // ****************************************

    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= mem_bus.reg_write;
        end
    end

    always_ff @(posedge i_clock) begin
        wb_dest_reg <= mem_bus.dest_reg;
        wb_data     <= wb_data_next;
    end

endmodule

`default_nettype wire
